//--- include/e100_consts.svh
`ifndef E100_CONSTS_SVH
`define E100_CONSTS_SVH

// width of the bus, the memory words and every register
`define E100_WORD_WIDTH 32

// memory addressing
`define E100_ADDR_WIDTH 8
`define E100_MEM_DEPTH 256

// sequencer state code
`define E100_STATE_WIDTH 6

`endif

//--- logic/e100_isa_pkg.sv
`default_nettype none

`include "e100_consts.svh"

package e100_isa_pkg;

    // one bus word
    typedef logic [`E100_WORD_WIDTH-1:0] word_t;

    // word address into the memory
    typedef logic [`E100_ADDR_WIDTH-1:0] addr_t;

    // opcodes occupy a full word; anything not listed decodes as a no-op
    typedef enum logic [`E100_WORD_WIDTH-1:0] {
        OP_HALT = 32'd0,
        OP_ADD  = 32'd1,
        OP_SUB  = 32'd2,
        OP_CP   = 32'd5,
        OP_AND  = 32'd6,
        OP_OR   = 32'd7,
        OP_NOT  = 32'd8,
        OP_BE   = 32'd13,
        OP_BNE  = 32'd14,
        OP_BLT  = 32'd15
    } opcode_t;

endpackage

`default_nettype wire

//--- logic/e100_ctrl_pkg.sv
`default_nettype none

`include "e100_consts.svh"

package e100_ctrl_pkg;

    import e100_isa_pkg::*;

    // execute states of one instruction are consecutive codes
    typedef enum logic [`E100_STATE_WIDTH-1:0] {
        S_RESET,
        S_FETCH1, S_FETCH2, S_FETCH3, S_FETCH4, S_FETCH5, S_FETCH6, S_FETCH7, S_FETCH8,
        S_DECODE,
        S_HALT,
        S_ADD1, S_ADD2, S_ADD3, S_ADD4, S_ADD5, S_ADD6,
        S_SUB1, S_SUB2, S_SUB3, S_SUB4, S_SUB5, S_SUB6,
        S_AND1, S_AND2, S_AND3, S_AND4, S_AND5, S_AND6,
        S_OR1, S_OR2, S_OR3, S_OR4, S_OR5, S_OR6,
        S_NOT1, S_NOT2, S_NOT3, S_NOT4,
        S_CP1, S_CP2, S_CP3, S_CP4,
        S_BE1, S_BE2, S_BE3, S_BE4, S_BE5, S_BE6,
        S_BNE1, S_BNE2, S_BNE3, S_BNE4, S_BNE5, S_BNE6,
        S_BLT1, S_BLT2, S_BLT3, S_BLT4, S_BLT5, S_BLT6
    } state_t;

    // the one driver of the shared bus
    typedef enum logic [3:0] {
        SRC_NONE,
        SRC_IAR,
        SRC_PLUS1,
        SRC_ADD,
        SRC_SUB,
        SRC_BIT_AND,
        SRC_BIT_OR,
        SRC_BIT_NOT,
        SRC_ARG1,
        SRC_ARG2,
        SRC_ARG3,
        SRC_MEMORY
    } bus_source_t;

    typedef struct packed {
        bus_source_t bus_source;
        logic        iar_write;
        logic        opcode_write;
        logic        arg1_write;
        logic        arg2_write;
        logic        arg3_write;
        logic        op1_write;
        logic        op2_write;
        logic        address_write;
        logic        memory_write;
    } ctrl_t;

    // less is signed op1 < op2
    typedef struct packed {
        logic equal;
        logic less;
    } flags_t;

    // first execute state for an opcode, unknown ones go back through reset
    function automatic state_t exec_first_state(opcode_t opcode);
        case (opcode)
            OP_HALT: return S_HALT;
            OP_ADD:  return S_ADD1;
            OP_SUB:  return S_SUB1;
            OP_AND:  return S_AND1;
            OP_OR:   return S_OR1;
            OP_NOT:  return S_NOT1;
            OP_CP:   return S_CP1;
            OP_BE:   return S_BE1;
            OP_BNE:  return S_BNE1;
            OP_BLT:  return S_BLT1;
            default: return S_RESET;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/e100_alu.sv
`timescale 1ns/1ps
`default_nettype none

module e100_alu
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;
(
    input  word_t       op1,
    input  word_t       op2,
    input  bus_source_t source,
    output word_t       result,
    output flags_t      flags
);

    always_comb begin
        case (source)
            SRC_ADD: begin
                result = op1 + op2;
            end
            SRC_SUB: begin
                result = op1 - op2;
            end
            SRC_BIT_AND: begin
                result = op1 & op2;
            end
            SRC_BIT_OR: begin
                result = op1 | op2;
            end
            SRC_BIT_NOT: begin
                // complement of op1 only
                result = ~op1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch conditions
    assign flags = '{equal: (op1 == op2), less: ($signed(op1) < $signed(op2))};

endmodule

`default_nettype wire

//--- logic/e100_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "e100_consts.svh"

module e100_datapath
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;
(
    input  wire     clock,
    input  wire     reset,
    input  ctrl_t   ctrl,
    input  word_t   read_data,
    output word_t   bus,
    output addr_t   mem_address,
    output opcode_t opcode,
    output flags_t  flags
);

    word_t   iar;
    word_t   iar_plus1;
    opcode_t opcode_reg;
    word_t   arg1;
    word_t   arg2;
    word_t   arg3;
    word_t   op1;
    word_t   op2;
    addr_t   address;
    word_t   alu_result;

    assign iar_plus1 = iar + word_t'(1);

    e100_alu alu (
        .op1    (op1),
        .op2    (op2),
        .source (ctrl.bus_source),
        .result (alu_result),
        .flags  (flags)
    );

    // shared bus with one source per cycle
    always_comb begin
        case (ctrl.bus_source)
            SRC_IAR: begin
                bus = iar;
            end
            SRC_PLUS1: begin
                bus = iar_plus1;
            end
            SRC_ADD, SRC_SUB, SRC_BIT_AND, SRC_BIT_OR, SRC_BIT_NOT: begin
                bus = alu_result;
            end
            SRC_ARG1: begin
                bus = arg1;
            end
            SRC_ARG2: begin
                bus = arg2;
            end
            SRC_ARG3: begin
                bus = arg3;
            end
            SRC_MEMORY: begin
                bus = read_data;
            end
            default: begin
                bus = '0;
            end
        endcase
    end

    // each register captures the bus on its own strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            iar        <= '0;
            opcode_reg <= OP_HALT;
            arg1       <= '0;
            arg2       <= '0;
            arg3       <= '0;
            op1        <= '0;
            op2        <= '0;
            address    <= '0;
        end else begin
            if (ctrl.iar_write) begin
                iar <= bus;
            end
            if (ctrl.opcode_write) begin
                opcode_reg <= opcode_t'(bus);
            end
            if (ctrl.arg1_write) begin
                arg1 <= bus;
            end
            if (ctrl.arg2_write) begin
                arg2 <= bus;
            end
            if (ctrl.arg3_write) begin
                arg3 <= bus;
            end
            if (ctrl.op1_write) begin
                op1 <= bus;
            end
            if (ctrl.op2_write) begin
                op2 <= bus;
            end
            if (ctrl.address_write) begin
                address <= bus[`E100_ADDR_WIDTH-1:0];
            end
        end
    end

    assign mem_address = address;
    assign opcode      = opcode_reg;

    // a program address must fit the memory without wrapping
    address_in_range: assert property (
        @(posedge clock) disable iff (reset)
        ctrl.address_write |-> (bus[`E100_WORD_WIDTH-1:`E100_ADDR_WIDTH] == '0)
    );

endmodule

`default_nettype wire

//--- logic/e100_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "e100_consts.svh"

module e100_memory
    import e100_isa_pkg::*;
(
    input  wire   clock,
    input  addr_t mem_address,
    input  word_t write_data,
    input  wire   memory_write,
    output word_t read_data,
    input  wire   load_write,
    input  addr_t load_address,
    input  word_t load_data,
    input  addr_t peek_address,
    output word_t peek_data
);

    word_t mem [`E100_MEM_DEPTH];

    // single write port, the load port has priority
    always_ff @(posedge clock) begin
        if (load_write) begin
            mem[load_address] <= load_data;
        end else if (memory_write) begin
            mem[mem_address] <= write_data;
        end
    end

    // asynchronous reads
    assign read_data = mem[mem_address];
    assign peek_data = mem[peek_address];

    // loading only happens while the core sits in reset
    load_while_idle: assert property (
        @(posedge clock) !(load_write && memory_write)
    );

endmodule

`default_nettype wire

//--- logic/e100_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "e100_consts.svh"

module e100_sequencer
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;
(
    input  wire     clock,
    input  wire     reset,
    input  opcode_t opcode,
    input  flags_t  flags,
    output ctrl_t   ctrl,
    output logic    halted
);

    state_t state;
    state_t next_state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_RESET;
        end else begin
            state <= next_state;
        end
    end

    // most states just step to the following code
    always_comb begin
        case (state)
            S_DECODE: begin
                next_state = exec_first_state(opcode);
            end
            S_HALT: begin
                next_state = S_HALT;
            end
            S_ADD6, S_SUB6, S_AND6, S_OR6, S_NOT4, S_CP4, S_BE6, S_BNE6, S_BLT6: begin
                next_state = S_FETCH1;
            end
            // taken branches go on to the IAR load
            S_BE5: begin
                next_state = flags.equal ? S_BE6 : S_FETCH1;
            end
            S_BNE5: begin
                next_state = flags.equal ? S_FETCH1 : S_BNE6;
            end
            S_BLT5: begin
                next_state = flags.less ? S_BLT6 : S_FETCH1;
            end
            default: begin
                next_state = state_t'(state + `E100_STATE_WIDTH'(1));
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            S_FETCH1: begin
                ctrl.bus_source    = SRC_IAR;
                ctrl.address_write = 1'b1;
            end
            S_FETCH2: begin
                ctrl.bus_source   = SRC_MEMORY;
                ctrl.opcode_write = 1'b1;
            end
            // step to the next instruction word
            S_FETCH3, S_FETCH5, S_FETCH7: begin
                ctrl.bus_source    = SRC_PLUS1;
                ctrl.iar_write     = 1'b1;
                ctrl.address_write = 1'b1;
            end
            S_FETCH4: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.arg1_write = 1'b1;
            end
            S_FETCH6: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.arg2_write = 1'b1;
            end
            S_FETCH8: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.arg3_write = 1'b1;
            end
            // IAR now points past arg3
            S_DECODE: begin
                ctrl.bus_source = SRC_PLUS1;
                ctrl.iar_write  = 1'b1;
            end
            S_ADD1, S_SUB1, S_AND1, S_OR1, S_NOT1, S_CP1, S_BE1, S_BNE1, S_BLT1: begin
                ctrl.bus_source    = SRC_ARG2;
                ctrl.address_write = 1'b1;
            end
            S_ADD2, S_SUB2, S_AND2, S_OR2, S_NOT2, S_BE2, S_BNE2, S_BLT2: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.op1_write  = 1'b1;
            end
            // cp parks the source word in arg3
            S_CP2: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.arg3_write = 1'b1;
            end
            S_ADD3, S_SUB3, S_AND3, S_OR3, S_BE3, S_BNE3, S_BLT3: begin
                ctrl.bus_source    = SRC_ARG3;
                ctrl.address_write = 1'b1;
            end
            S_ADD4, S_SUB4, S_AND4, S_OR4, S_BE4, S_BNE4, S_BLT4: begin
                ctrl.bus_source = SRC_MEMORY;
                ctrl.op2_write  = 1'b1;
            end
            S_ADD5, S_SUB5, S_AND5, S_OR5, S_NOT3, S_CP3: begin
                ctrl.bus_source    = SRC_ARG1;
                ctrl.address_write = 1'b1;
            end
            S_ADD6: begin
                ctrl.bus_source   = SRC_ADD;
                ctrl.memory_write = 1'b1;
            end
            S_SUB6: begin
                ctrl.bus_source   = SRC_SUB;
                ctrl.memory_write = 1'b1;
            end
            S_AND6: begin
                ctrl.bus_source   = SRC_BIT_AND;
                ctrl.memory_write = 1'b1;
            end
            S_OR6: begin
                ctrl.bus_source   = SRC_BIT_OR;
                ctrl.memory_write = 1'b1;
            end
            S_NOT4: begin
                ctrl.bus_source   = SRC_BIT_NOT;
                ctrl.memory_write = 1'b1;
            end
            S_CP4: begin
                ctrl.bus_source   = SRC_ARG3;
                ctrl.memory_write = 1'b1;
            end
            // taken branch loads the target into IAR
            S_BE6, S_BNE6, S_BLT6: begin
                ctrl.bus_source = SRC_ARG1;
                ctrl.iar_write  = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign halted = (state == S_HALT);

    halt_is_quiet: assert property (
        @(posedge clock) disable iff (reset)
        (state == S_HALT) |-> (ctrl == '0)
    );

    // the address register must be stable while memory is written
    no_write_during_address: assert property (
        @(posedge clock) disable iff (reset)
        !(ctrl.memory_write && ctrl.address_write)
    );

endmodule

`default_nettype wire

//--- logic/e100_core.sv
`timescale 1ns/1ps
`default_nettype none

module e100_core
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;
(
    input  wire   clock,
    input  wire   reset,
    input  wire   load_write,
    input  addr_t load_address,
    input  word_t load_data,
    input  addr_t peek_address,
    output word_t peek_data,
    output logic  halted
);

    ctrl_t   ctrl;
    word_t   bus;
    word_t   read_data;
    addr_t   mem_address;
    opcode_t opcode;
    flags_t  flags;

    e100_sequencer sequencer (
        .clock  (clock),
        .reset  (reset),
        .opcode (opcode),
        .flags  (flags),
        .ctrl   (ctrl),
        .halted (halted)
    );

    e100_datapath datapath (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (ctrl),
        .read_data   (read_data),
        .bus         (bus),
        .mem_address (mem_address),
        .opcode      (opcode),
        .flags       (flags)
    );

    // memory writes always take their data from the bus
    e100_memory memory (
        .clock        (clock),
        .mem_address  (mem_address),
        .write_data   (bus),
        .memory_write (ctrl.memory_write),
        .read_data    (read_data),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .peek_data    (peek_data)
    );

endmodule

`default_nettype wire

//--- test/e100_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module e100_core_tb
    import e100_isa_pkg::*;
();

    typedef struct packed {
        opcode_t opcode;
        word_t   a;
        word_t   b;
        word_t   expected;
    } test_row_t;

    localparam int num_rows = 17;
    // worst row is a taken blt: reset state, three fetch+decode passes, blt and cp
    localparam int longest_row_cycles = 1 + 3 * 9 + 6 + 4;
    localparam int row_cycle_limit = longest_row_cycles + 2;
    localparam addr_t result_address = 8'd102;

    logic  clock;
    logic  reset;
    logic  load_write;
    addr_t load_address;
    word_t load_data;
    addr_t peek_address;
    word_t peek_data;
    logic  halted;

    integer    seed;
    test_row_t rows [num_rows];

    e100_core UUT (
        .clock        (clock),
        .reset        (reset),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data),
        .peek_address (peek_address),
        .peek_data    (peek_data),
        .halted       (halted)
    );

    always #2 clock = ~clock;

    function automatic word_t fill_word(addr_t address);
        return {8'hc3, address, ~address, address};
    endfunction

    function automatic logic is_branch(opcode_t opcode);
        return opcode inside {OP_BE, OP_BNE, OP_BLT};
    endfunction

    // word expected at address 102 once the program halts
    function automatic word_t reference_result(opcode_t opcode, word_t a, word_t b);
        case (opcode)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_NOT:  return ~a;
            OP_CP:   return a;
            OP_BE:   return (a == b) ? 32'd1 : 32'd0;
            OP_BNE:  return (a != b) ? 32'd1 : 32'd0;
            OP_BLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return fill_word(result_address);
        endcase
    endfunction

    function automatic test_row_t make_row(opcode_t opcode, word_t a, word_t b);
        test_row_t row;
        row.opcode   = opcode;
        row.a        = a;
        row.b        = b;
        row.expected = reference_result(opcode, a, b);
        return row;
    endfunction

    // instruction under test at 0, fall-through at 4, branch target at 12
    function automatic word_t program_word(test_row_t row, int address);
        case (address)
            0:       return word_t'(row.opcode);
            1:       return is_branch(row.opcode) ? 32'd12 : 32'd102;
            2:       return 32'd100;
            3:       return 32'd101;
            4:       return is_branch(row.opcode) ? word_t'(OP_CP) : word_t'(OP_HALT);
            5:       return is_branch(row.opcode) ? 32'd102 : 32'd0;
            6:       return is_branch(row.opcode) ? 32'd103 : 32'd0;
            12:      return word_t'(OP_CP);
            13:      return 32'd102;
            14:      return 32'd104;
            // zero words decode as halt
            default: return 32'd0;
        endcase
    endfunction

    task automatic build_table();
        word_t shared;
        seed     = 32'hcc7c_16ca;
        rows[0]  = make_row(OP_ADD, $random(seed), $random(seed));
        rows[1]  = make_row(OP_ADD, 32'hffff_ffff, 32'd1);
        rows[2]  = make_row(OP_SUB, $random(seed), $random(seed));
        rows[3]  = make_row(OP_SUB, 32'd0, 32'd1);
        rows[4]  = make_row(OP_AND, $random(seed), $random(seed));
        rows[5]  = make_row(OP_OR, $random(seed), $random(seed));
        rows[6]  = make_row(OP_NOT, $random(seed), $random(seed));
        rows[7]  = make_row(OP_CP, $random(seed), $random(seed));
        shared   = $random(seed);
        rows[8]  = make_row(OP_BE, shared, shared);
        rows[9]  = make_row(OP_BE, $random(seed), $random(seed));
        shared   = $random(seed);
        rows[10] = make_row(OP_BNE, shared, shared);
        rows[11] = make_row(OP_BNE, $random(seed), $random(seed));
        // signed compare, negative against positive both ways
        rows[12] = make_row(OP_BLT, 32'hffff_fffb, 32'd3);
        rows[13] = make_row(OP_BLT, 32'd3, 32'hffff_fffb);
        rows[14] = make_row(OP_BLT, 32'h8000_0000, 32'h7fff_ffff);
        rows[15] = make_row(OP_BLT, 32'd77, 32'd77);
        rows[16] = make_row(opcode_t'(32'd20), $random(seed), $random(seed));
    endtask

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic load_word(addr_t address, word_t data);
        @(negedge clock);
        load_write   = 1'b1;
        load_address = address;
        load_data    = data;
    endtask

    task automatic peek_word(addr_t address, output word_t value);
        @(negedge clock);
        peek_address = address;
        #1;
        value = peek_data;
    endtask

    // counts cycles from the release of reset
    task automatic wait_for_halt(int row_index);
        int cycles;
        cycles = 1;
        while (halted !== 1'b1) begin
            if (cycles >= row_cycle_limit) begin
                $display("timeout: core never halted in row %0d within %0d cycles",
                         row_index, cycles);
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic run_row(int index);
        test_row_t row;
        word_t     value;
        row = rows[index];
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        compare_bit("halted", 1'b0, halted);
        for (int address = 0; address < 20; address++) begin
            load_word(addr_t'(address), program_word(row, address));
        end
        load_word(8'd100, row.a);
        load_word(8'd101, row.b);
        load_word(result_address, fill_word(result_address));
        // branch markers, 0 for fall-through and 1 for taken
        load_word(8'd103, 32'd0);
        load_word(8'd104, 32'd1);
        @(negedge clock);
        load_write = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        compare_bit("halted", 1'b0, halted);
        @(negedge clock);
        compare_bit("halted", 1'b0, halted);
        wait_for_halt(index);
        // halt holds and memory stays put
        repeat (10) begin
            peek_word(result_address, value);
            compare_bit("halted", 1'b1, halted);
            compare_word("peek_data[102]", row.expected, value);
        end
        peek_word(8'd100, value);
        compare_word("peek_data[100]", row.a, value);
        peek_word(8'd101, value);
        compare_word("peek_data[101]", row.b, value);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        load_write   = 1'b0;
        load_address = '0;
        load_data    = '0;
        peek_address = '0;
        build_table();
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- e100_core.f
+incdir+include
logic/e100_isa_pkg.sv
logic/e100_ctrl_pkg.sv
logic/e100_alu.sv
logic/e100_datapath.sv
logic/e100_memory.sv
logic/e100_sequencer.sv
logic/e100_core.sv
test/e100_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= e100_core_tb
RTL_TOP   ?= e100_core
FILELIST  ?= e100_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
